// File: flist.f
+incdir+rtl
rtl/bossPkg.sv
rtl/bossController.sv
rtl/bossMotion.sv
rtl/missileBuffer.sv
rtl/bossRenderer.sv
rtl/bossUnit.sv
test/bossUnit_checker.sv
test/bossUnitTb.sv

// File: rtl/bossController.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module bossController
    import bossPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      startOfFrame,
    input  logic      bossHit,
    input  pixelOutT  pixelOut,
    output logic      frameStep,
    output logic      fire,
    output bossStateT bossState
);

    localparam int CoolW = $clog2(`COOLDOWN_FRAMES);
    localparam int LivesW = $clog2(`LIVES + 1);
    localparam int FadeW = $clog2(`DAMAGE_FRAMES);
    localparam int HideW = $clog2(`HIDE_FRAMES);

    logic [CoolW-1:0] cooldownCnt;
    logic [LivesW-1:0] lives;
    logic [FadeW-1:0] fadeCnt;
    logic [HideW-1:0] hideCnt;
    logic dead;
    logic faded;
    logic hidden;
    logic countedHit;
    logic lastHit;

    assign frameStep = startOfFrame & enable;

    // a hit only counts on a pixel the boss actually drew, and not while it flashes
    assign countedHit = bossHit & pixelOut.bossDraw & ~faded & ~dead;
    assign lastHit = countedHit && (lives == LivesW'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cooldownCnt <= '0;
            fire <= 1'b0;
        end else begin
            fire <= 1'b0;
            if (frameStep) begin
                if (cooldownCnt == CoolW'(`COOLDOWN_FRAMES - 1)) begin
                    cooldownCnt <= '0;
                    // suppress the shot if the killing hit lands on this same edge
                    fire <= ~(dead | lastHit);
                end else begin
                    cooldownCnt <= cooldownCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lives <= LivesW'(`LIVES);
            faded <= 1'b0;
            fadeCnt <= '0;
            dead <= 1'b0;
        end else if (countedHit) begin
            lives <= lives - 1'b1;
            faded <= 1'b1;
            fadeCnt <= '0;
            if (lastHit) begin
                dead <= 1'b1;
            end
        end else if (frameStep && faded) begin
            if (fadeCnt == FadeW'(`DAMAGE_FRAMES - 1)) begin
                faded <= 1'b0;
            end
            fadeCnt <= fadeCnt + 1'b1;
        end
    end

    // the body stays on screen for a while after death
    always_ff @(posedge clk) begin
        if (rst) begin
            hideCnt <= '0;
            hidden <= 1'b0;
        end else if (frameStep && dead && !hidden) begin
            if (hideCnt == HideW'(`HIDE_FRAMES - 1)) begin
                hidden <= 1'b1;
            end
            hideCnt <= hideCnt + 1'b1;
        end
    end

    assign bossState = '{dead: dead, faded: faded, hidden: hidden};

endmodule

`default_nettype wire

// File: rtl/bossMotion.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module bossMotion
    import bossPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  frameStep,
    input  logic  fire,
    output pointT bossPos
);

    logic flipX;
    logic flipY;
    logic [15:0] lfsr;
    logic lfsrFb;
    coordT velX;
    coordT velY;
    coordT nextX;
    coordT nextY;
    logic bounceX;
    logic bounceY;

    // a set flip bit runs that axis against its initial direction
    assign velX = flipX ? coordT'(-`BOSS_DX) : coordT'(`BOSS_DX);
    assign velY = flipY ? coordT'(-`BOSS_DY) : coordT'(`BOSS_DY);

    assign nextX = bossPos.x + velX;
    assign nextY = bossPos.y + velY;

    assign bounceX = (nextX < 0) || (nextX > coordT'(`SCREEN_W - `BOSS_SIZE));
    assign bounceY = (nextY < 0) || (nextY > coordT'(`SCREEN_H - `BOSS_SIZE));

    assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            bossPos <= '{x: coordT'(`INIT_X), y: coordT'(`INIT_Y)};
            flipX <= 1'b0;
            flipY <= 1'b0;
            lfsr <= `LFSR_SEED;
        end else if (frameStep) begin
            lfsr <= {lfsr[14:0], lfsrFb};
            // on a bounce the axis holds for this frame and only turns around
            if (bounceX) begin
                flipX <= ~flipX;
            end else begin
                bossPos.x <= nextX;
            end
            if (bounceY) begin
                flipY <= ~flipY;
            end else begin
                bossPos.y <= nextY;
            end
        end else if (fire) begin
            // fire always trails the frame step by a cycle
            if (lfsr[0]) begin
                flipX <= ~flipX;
            end else begin
                flipY <= ~flipY;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/bossPkg.sv
`default_nettype none

package bossPkg;

    typedef logic signed [10:0] coordT;

    typedef logic [7:0] rgbT;

    typedef struct packed {
        coordT x;
        coordT y;
    } pointT;

    typedef struct packed {
        logic dead;
        logic faded;
        logic hidden;
    } bossStateT;

    typedef struct packed {
        logic  active;
        coordT x;
        coordT y;
    } missileT;

    typedef struct packed {
        logic bossDraw;
        rgbT  bossRgb;
        logic missileDraw;
    } pixelOutT;

endpackage

`default_nettype wire

// File: rtl/bossRenderer.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module bossRenderer
    import bossPkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  pointT                        pixel,
    input  pointT                        bossPos,
    input  bossStateT                    bossState,
    input  missileT [`MISSILE_SLOTS-1:0] missiles,
    output pixelOutT                     pixelOut,
    output logic [`MISSILE_SLOTS-1:0]    hitMask
);

    logic insideBoss;
    logic [`MISSILE_SLOTS-1:0] missileCover;
    logic bossDrawQ;
    logic missileDrawQ;
    rgbT bossRgbQ;

    assign insideBoss = (pixel.x >= bossPos.x)
        && (pixel.x < bossPos.x + coordT'(`BOSS_SIZE))
        && (pixel.y >= bossPos.y)
        && (pixel.y < bossPos.y + coordT'(`BOSS_SIZE));

    always_comb begin
        for (int i = 0; i < `MISSILE_SLOTS; i++) begin
            missileCover[i] = missiles[i].active
                && (pixel.x >= missiles[i].x)
                && (pixel.x < missiles[i].x + coordT'(`MISSILE_SIZE))
                && (pixel.y >= missiles[i].y)
                && (pixel.y < missiles[i].y + coordT'(`MISSILE_SIZE));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bossDrawQ <= 1'b0;
            missileDrawQ <= 1'b0;
            hitMask <= '0;
        end else begin
            bossDrawQ <= insideBoss && !bossState.hidden;
            missileDrawQ <= |missileCover;
            hitMask <= missileCover;
        end
    end

    // the boss goes black while it is damaged
    always_ff @(posedge clk) begin
        bossRgbQ <= bossState.faded ? rgbT'(0) : rgbT'(`BOSS_COLOR);
    end

    assign pixelOut = '{bossDraw: bossDrawQ, bossRgb: bossRgbQ, missileDraw: missileDrawQ};

endmodule

`default_nettype wire

// File: rtl/bossUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module bossUnit
    import bossPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      startOfFrame,
    input  pointT     pixel,
    input  logic      bossHit,
    input  logic      missileHit,
    output pixelOutT  pixelOut,
    output bossStateT bossState
);

    logic frameStep;
    logic fire;
    pointT bossPos;
    missileT [`MISSILE_SLOTS-1:0] missiles;
    logic [`MISSILE_SLOTS-1:0] hitMask;

    bossController controller (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .startOfFrame (startOfFrame),
        .bossHit      (bossHit),
        .pixelOut     (pixelOut),
        .frameStep    (frameStep),
        .fire         (fire),
        .bossState    (bossState)
    );

    bossMotion motion (
        .clk       (clk),
        .rst       (rst),
        .frameStep (frameStep),
        .fire      (fire),
        .bossPos   (bossPos)
    );

    missileBuffer missileBuf (
        .clk        (clk),
        .rst        (rst),
        .frameStep  (frameStep),
        .fire       (fire),
        .missileHit (missileHit),
        .bossPos    (bossPos),
        .hitMask    (hitMask),
        .missiles   (missiles)
    );

    bossRenderer renderer (
        .clk       (clk),
        .rst       (rst),
        .pixel     (pixel),
        .bossPos   (bossPos),
        .bossState (bossState),
        .missiles  (missiles),
        .pixelOut  (pixelOut),
        .hitMask   (hitMask)
    );

endmodule

`default_nettype wire

// File: rtl/boss_defines.svh
`ifndef BOSS_DEFINES_SVH
`define BOSS_DEFINES_SVH

// visible screen area in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// boss square and its start position (top-left corner)
`define BOSS_SIZE 64
`define INIT_X 287
`define INIT_Y 49

// boss speed in whole pixels per frame
`define BOSS_DX (2)
`define BOSS_DY (-1)

// frame counts
`define COOLDOWN_FRAMES 20
`define LIVES 3
`define DAMAGE_FRAMES 10
`define HIDE_FRAMES 10

// missile pool with the spawn point taken relative to the boss top-left
`define MISSILE_SLOTS 8
`define MISSILE_SIZE 4
`define MISSILE_DY 4
`define MISSILE_XOFF 30
`define MISSILE_YOFF 60

// RRRGGGBB colours
`define BOSS_COLOR 8'hE4
`define MISSILE_COLOR 8'hD0

// Fibonacci LFSR with taps 16, 14, 13, 11
`define LFSR_SEED 16'hACE1

`endif

// File: rtl/missileBuffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module missileBuffer
    import bossPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       frameStep,
    input  logic                       fire,
    input  logic                       missileHit,
    input  pointT                      bossPos,
    input  logic [`MISSILE_SLOTS-1:0]  hitMask,
    output missileT [`MISSILE_SLOTS-1:0] missiles
);

    pointT spawnPos;

    assign spawnPos = '{
        x: bossPos.x + coordT'(`MISSILE_XOFF),
        y: bossPos.y + coordT'(`MISSILE_YOFF)
    };

    for (genvar i = 0; i < `MISSILE_SLOTS; i++) begin : gSlot
        // slots fan out left to right with speeds from -7 to +7 in odd steps
        localparam coordT SpeedX = coordT'((i - 4) * 2 + 1);

        logic active;
        pointT pos;
        pointT nextPos;
        logic offScreen;

        assign nextPos = '{x: pos.x + SpeedX, y: pos.y + coordT'(`MISSILE_DY)};

        assign offScreen = (nextPos.y >= coordT'(`SCREEN_H))
            || (nextPos.x < 0)
            || (nextPos.x > coordT'(`SCREEN_W - 1));

        always_ff @(posedge clk) begin
            if (rst) begin
                active <= 1'b0;
            end else if (missileHit && hitMask[i]) begin
                active <= 1'b0;
            end else if (fire && !active) begin
                active <= 1'b1;
            end else if (frameStep && active && offScreen) begin
                active <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (fire && !active) begin
                pos <= spawnPos;
            end else if (frameStep && active) begin
                pos <= nextPos;
            end
        end

        assign missiles[i] = '{active: active, x: pos.x, y: pos.y};
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module bossUnitTb -Mdir obj_dir
./obj_dir/VbossUnitTb

// File: test/bossUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "boss_defines.svh"

module bossUnitTb
    import bossPkg::*;
();

    localparam int NumFrames = 200;
    localparam int FrameCycles = 40;

    logic clk;
    logic rst;
    logic enable;
    logic startOfFrame;
    pointT pixel;
    logic bossHit;
    logic missileHit;
    pixelOutT pixelOut;
    bossStateT bossState;
    integer seed;

    // reference model state that is updated once per rising edge
    pointT mPos;
    logic mFlipX;
    logic mFlipY;
    logic [15:0] mLfsr;
    logic mFire;
    int mCool;
    int mLives;
    int mFadeCnt;
    int mHideCnt;
    int shots;
    bossStateT mState;
    pixelOutT mOut;
    missileT mSlot [`MISSILE_SLOTS];
    logic [`MISSILE_SLOTS-1:0] mHitMask;

    bossUnit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failNow(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkPixel(input pixelOutT got, input pixelOutT exp);
        if (got !== exp) begin
            failNow($sformatf("[FAIL] pixelOut got %h expected %h at %0t", got, exp, $time));
        end
    endtask

    task automatic checkState(input bossStateT got, input bossStateT exp);
        if (got !== exp) begin
            failNow($sformatf("[FAIL] bossState got %h expected %h at %0t", got, exp, $time));
        end
    endtask

    function automatic logic covers(pointT p, coordT x, coordT y, int size);
        return p.x >= x && p.x < x + size && p.y >= y && p.y < y + size;
    endfunction

    task automatic modelEdge();
        logic step;
        logic counted;
        logic lastHit;
        logic fireNext;
        logic wasActive;
        logic offScreen;
        logic [`MISSILE_SLOTS-1:0] covered;
        int nx;
        int ny;
        step = startOfFrame && enable;
        counted = bossHit && mOut.bossDraw && !mState.faded && !mState.dead;
        lastHit = counted && (mLives == 1);
        fireNext = 1'b0;
        if (mFire) begin
            shots++;
        end
        // the renderer registers what the state was before this edge
        for (int i = 0; i < `MISSILE_SLOTS; i++) begin
            covered[i] = mSlot[i].active
                && covers(pixel, mSlot[i].x, mSlot[i].y, `MISSILE_SIZE);
        end
        mOut.bossDraw = covers(pixel, mPos.x, mPos.y, `BOSS_SIZE) && !mState.hidden;
        mOut.bossRgb = mState.faded ? 8'h00 : `BOSS_COLOR;
        mOut.missileDraw = |covered;
        if (step && mState.dead && !mState.hidden) begin
            mState.hidden = (mHideCnt == `HIDE_FRAMES - 1);
            mHideCnt++;
        end
        if (step) begin
            fireNext = (mCool == `COOLDOWN_FRAMES - 1) && !(mState.dead || lastHit);
            mCool = (mCool == `COOLDOWN_FRAMES - 1) ? 0 : mCool + 1;
        end
        if (counted) begin
            mLives--;
            mState.faded = 1'b1;
            mFadeCnt = 0;
            mState.dead = lastHit;
        end else if (step && mState.faded) begin
            mState.faded = (mFadeCnt != `DAMAGE_FRAMES - 1);
            mFadeCnt++;
        end
        for (int i = 0; i < `MISSILE_SLOTS; i++) begin
            wasActive = mSlot[i].active;
            nx = mSlot[i].x + (i - 4) * 2 + 1;
            ny = mSlot[i].y + `MISSILE_DY;
            offScreen = ny >= `SCREEN_H || nx < 0 || nx >= `SCREEN_W;
            if (missileHit && mHitMask[i]) begin
                mSlot[i].active = 1'b0;
            end else if (mFire && !wasActive) begin
                mSlot[i].active = 1'b1;
            end else if (step && wasActive && offScreen) begin
                mSlot[i].active = 1'b0;
            end
            if (mFire && !wasActive) begin
                mSlot[i].x = mPos.x + coordT'(`MISSILE_XOFF);
                mSlot[i].y = mPos.y + coordT'(`MISSILE_YOFF);
            end else if (step && wasActive) begin
                mSlot[i].x = coordT'(nx);
                mSlot[i].y = coordT'(ny);
            end
        end
        if (step) begin
            mLfsr = {mLfsr[14:0], mLfsr[15] ^ mLfsr[13] ^ mLfsr[12] ^ mLfsr[10]};
            nx = mPos.x + (mFlipX ? -`BOSS_DX : `BOSS_DX);
            ny = mPos.y + (mFlipY ? -`BOSS_DY : `BOSS_DY);
            // a bounce turns the axis around and holds it for this frame
            if (nx < 0 || nx > `SCREEN_W - `BOSS_SIZE) begin
                mFlipX = ~mFlipX;
            end else begin
                mPos.x = coordT'(nx);
            end
            if (ny < 0 || ny > `SCREEN_H - `BOSS_SIZE) begin
                mFlipY = ~mFlipY;
            end else begin
                mPos.y = coordT'(ny);
            end
        end else if (mFire) begin
            if (mLfsr[0]) begin
                mFlipX = ~mFlipX;
            end else begin
                mFlipY = ~mFlipY;
            end
        end
        mFire = fireNext;
        mHitMask = covered;
    endtask

    // half of the pixels land near the boss or near a live missile
    task automatic pickPixel(output pointT p);
        int r;
        int k;
        r = {$random(seed)} % 4;
        k = {$random(seed)} % `MISSILE_SLOTS;
        if (r < 2) begin
            p.x = coordT'({$random(seed)} % `SCREEN_W);
            p.y = coordT'({$random(seed)} % `SCREEN_H);
        end else if (r == 3 && mSlot[k].active) begin
            p.x = mSlot[k].x + coordT'({$random(seed)} % 8) - coordT'(2);
            p.y = mSlot[k].y + coordT'({$random(seed)} % 8) - coordT'(2);
        end else begin
            p.x = mPos.x + coordT'({$random(seed)} % 80) - coordT'(8);
            p.y = mPos.y + coordT'({$random(seed)} % 80) - coordT'(8);
        end
    endtask

    initial begin
        for (int i = 0; i < NumFrames * FrameCycles + 100; i++) begin
            @(posedge clk);
        end
        failNow("timeout: the run did not finish within its cycle budget");
    end

    initial begin
        logic frameEn;
        seed = 48;
        rst = 1'b1;
        enable = 1'b0;
        startOfFrame = 1'b0;
        pixel = '0;
        bossHit = 1'b0;
        missileHit = 1'b0;
        mPos = '{x: coordT'(`INIT_X), y: coordT'(`INIT_Y)};
        mFlipX = 1'b0;
        mFlipY = 1'b0;
        mLfsr = `LFSR_SEED;
        mFire = 1'b0;
        mCool = 0;
        mLives = `LIVES;
        mFadeCnt = 0;
        mHideCnt = 0;
        shots = 0;
        mState = '0;
        mOut = '{bossDraw: 1'b0, bossRgb: `BOSS_COLOR, missileDraw: 1'b0};
        mHitMask = '0;
        for (int i = 0; i < `MISSILE_SLOTS; i++) begin
            mSlot[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < NumFrames; f++) begin
            frameEn = ($random(seed) & 7) != 0;
            for (int c = 0; c < FrameCycles; c++) begin
                enable = frameEn;
                startOfFrame = (c == 0);
                pickPixel(pixel);
                bossHit = ($random(seed) & 255) == 0;
                missileHit = ($random(seed) & 15) == 0;
                @(negedge clk);
                modelEdge();
                checkPixel(pixelOut, mOut);
                checkState(bossState, mState);
            end
        end
        if (shots == 0) begin
            failNow("the boss never fired a shot during the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/bossUnit_checker.sv
`timescale 1ns/100ps
`default_nettype none

module bossUnit_checker
    import bossPkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      fire,
    input logic      bossHit,
    input bossStateT bossState
);

    // a shot is a single-cycle strobe
    assert property (@(posedge clk) disable iff (rst) fire |=> !fire)
        else $error("fire stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (rst) fire |-> !bossState.dead)
        else $error("fire pulsed while the boss is dead");

    assert property (@(posedge clk) disable iff (rst) bossState.hidden |-> bossState.dead)
        else $error("hidden is set while the boss is not dead");

    // only the killing hit sets dead, and that same hit starts the flash
    assert property (@(posedge clk) disable iff (rst)
        $rose(bossState.dead) |-> $past(bossHit) && bossState.faded)
        else $error("dead rose without a hit or without the damage flash");

endmodule

bind bossUnit bossUnit_checker bossCheck (
    .clk       (clk),
    .rst       (rst),
    .fire      (fire),
    .bossHit   (bossHit),
    .bossState (bossState)
);

`default_nettype wire
